// ==== all.f ====
common/demodPkg.sv
common/regBus.sv
rtl/axiLiteRegBridge.sv
ddc/ddc.sv
rtl/fmDemod.sv
bitsync/bitsync.sv
rtl/demod.sv
verification/tbClock.sv
verification/demodTb.sv

// ==== Makefile ====
# Verilator build for the demodulator core and its testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= demodTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= TESTS FAILED

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# the run fails when the simulation exits badly or its log holds the fail message.
run: $(BIN)
	$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/demodTb.sv ====
`default_nettype none

module demodTb
    import demodPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int       TIMEOUT = 1000;
    localparam axiResp_t OKAY    = 2'b00;
    localparam axiResp_t SLVERR  = 2'b10;

    logic clk, rst;
    regAddr_t awaddr, araddr;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    regData_t wdata, rdata;
    regStrb_t wstrb;
    axiResp_t bresp, rresp;
    sample_t iRx, qRx;
    logic sampleValid, demodBit, demodBitValid, demodDataValid;
    logic [7:0] demodData;

    // reference model state. It follows every sample that is sent.
    logic [31:0] refPhase, refFreqWord;
    longint refIPrev, refQPrev, refAcc;
    int refCount, refSps;
    logic refInvert;
    logic expBits[$];
    logic [7:0] expByte;
    logic chkBit;

    int seed = 32'h848a12d8;
    int phIdx, errors, checks, bitsSeen, bytesSeen, testErrors;
    axiResp_t resp;
    regData_t data;

    // cosine of k * 22.5 degrees at an amplitude of 100000. The sine is the
    // same table a quarter turn back.
    int cosTab[16] = '{100000, 92388, 70711, 38268, 0, -38268, -70711, -92388,
                       -100000, -92388, -70711, -38268, 0, 38268, 70711, 92388};

    tbClock clkGen (.clk(clk), .rst(rst));

    demod dut0 (.*);

    ////////////////////////////////////////////////////////////////////////////
    // reference model.

    // negation clamps the most negative 18 bit code at the positive limit.
    function automatic longint negClamp(input longint x);
        return (x == -131072) ? 131071 : -x;
    endfunction

    // one sample through the rotation, the discriminator and the
    // integrate-and-dump; a finished symbol pushes its bit to the queue.
    function automatic void refChain(input int iIn, input int qIn);
        longint iRot;
        longint qRot;
        longint step;
        case (refPhase[31:30])
            2'd0: begin
                iRot = iIn;
                qRot = qIn;
            end
            2'd1: begin
                iRot = qIn;
                qRot = negClamp(iIn);
            end
            2'd2: begin
                iRot = negClamp(iIn);
                qRot = negClamp(qIn);
            end
            default: begin
                iRot = negClamp(qIn);
                qRot = iIn;
            end
        endcase
        refPhase = refPhase + refFreqWord;
        // the shift of a signed longint floors toward minus infinity.
        step = (refIPrev * qRot - refQPrev * iRot) >>> 18;
        if (step > 131071) step = 131071;
        else if (step < -131072) step = -131072;
        refIPrev = iRot;
        refQPrev = qRot;
        refAcc = refAcc + step;
        refCount++;
        if (refCount == refSps) begin
            expBits.push_back((refAcc >= 0) ^ refInvert);
            refAcc = 0;
            refCount = 0;
        end
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // checks and host bus tasks.

    task automatic expectEqual(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", what, got, exp);
        end
    endtask

    task automatic reportTimeout(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
    endtask

    // a write presents address and data together, then holds bready low for
    // holdCycles cycles after bvalid to see that the response stays up.
    task automatic axiWrite(input regAddr_t addr, input regData_t wd, input regStrb_t strb,
                            input int holdCycles, output axiResp_t br);
        int n;
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= wd;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!(awready && wready) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) reportTimeout("awready and wready");
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!bvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) reportTimeout("bvalid");
        repeat (holdCycles) begin
            @(negedge clk);
            checks++;
            assert (bvalid) else begin
                errors++;
                $display("bvalid dropped before bready was given");
            end
        end
        br = bresp;
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axiRead(input regAddr_t addr, input int holdCycles,
                           output regData_t rd, output axiResp_t rr);
        int n;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!arready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) reportTimeout("arready");
        @(posedge clk);
        arvalid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!rvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT) reportTimeout("rvalid");
        repeat (holdCycles) begin
            @(negedge clk);
            checks++;
            assert (rvalid) else begin
                errors++;
                $display("rvalid dropped before rready was given");
            end
        end
        rd = rdata;
        rr = rresp;
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic regWrite(input regAddr_t addr, input regData_t wd, input regStrb_t strb);
        axiResp_t br;
        axiWrite(addr, wd, strb, 0, br);
        expectEqual("bresp", br, OKAY);
    endtask

    task automatic regRead(input regAddr_t addr, input regData_t exp);
        regData_t rd;
        axiResp_t rr;
        axiRead(addr, 0, rd, rr);
        expectEqual("rresp", rr, OKAY);
        expectEqual("rdata", rd, exp);
    endtask

    // disables the bitsync, loads a new setup and enables it again, which
    // restarts the symbol count and the byte phase.
    task automatic setupRun(input regData_t freqWord, input int sps, input logic inv);
        regWrite(12'h104, 32'h0, 4'hf);
        regWrite(12'h000, freqWord, 4'hf);
        regWrite(12'h100, sps, 4'hf);
        regWrite(12'h104, {30'd0, inv, 1'b1}, 4'hf);
        refFreqWord = freqWord;
        refSps = sps;
        refInvert = inv;
        refAcc = 0;
        refCount = 0;
        bitsSeen = 0;
        bytesSeen = 0;
    endtask

    // each bit steps the phase by carrier plus or minus dev table entries on
    // every sample of its symbol. Now and then an idle cycle is left.
    task automatic sendBits(input int nBits, input int carrier, input int dev);
        logic symBit;
        int iVal;
        int qVal;
        for (int b = 0; b < nBits; b++) begin
            symBit = $random(seed) & 1;
            for (int s = 0; s < refSps; s++) begin
                phIdx = phIdx + carrier + (symBit ? dev : -dev);
                iVal = cosTab[phIdx & 15];
                qVal = cosTab[(phIdx + 12) & 15];
                refChain(iVal, qVal);
                @(posedge clk);
                iRx <= sample_t'(iVal);
                qRx <= sample_t'(qVal);
                sampleValid <= 1'b1;
                if (($random(seed) & 7) == 0) begin
                    @(posedge clk);
                    sampleValid <= 1'b0;
                end
            end
        end
        @(posedge clk);
        sampleValid <= 1'b0;
    endtask

    // waits for the bits of a run, then allows a few cycles for stray ones.
    task automatic waitBits(input int target);
        int n;
        n = 0;
        while (bitsSeen < target && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (bitsSeen < target) reportTimeout("demodBitValid");
        repeat (4) @(posedge clk);
        expectEqual("bit count", bitsSeen, target);
        expectEqual("bits left in queue", expBits.size(), 0);
    endtask

    task automatic reportTest(input int num, input string name);
        if (errors == testErrors) $display("test %0d %s: ok", num, name);
        else $display("test %0d %s: %0d errors", num, name, errors - testErrors);
        testErrors = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // output checker. Outputs are sampled on the falling edge, away from the
    // rising edge where they change.
    always @(negedge clk) begin
        if (!rst && demodBitValid) begin
            checks++;
            assert (expBits.size() != 0) else begin
                errors++;
                $display("demodBitValid came with no expected bit left");
            end
            if (expBits.size() != 0) begin
                chkBit = expBits.pop_front();
                expectEqual("demodBit", demodBit, chkBit);
                expByte = {expByte[6:0], chkBit};
            end
            bitsSeen++;
        end
        // a byte completes on every eighth bit since enable, and it includes
        // the bit that arrives in the same cycle.
        if (!rst && demodDataValid) begin
            checks++;
            assert (demodBitValid && (bitsSeen % 8 == 0)) else begin
                errors++;
                $display("demodDataValid came after %0d bits and not on an eighth bit",
                         bitsSeen);
            end
            expectEqual("demodData", demodData, expByte);
            bytesSeen++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence.
    initial begin
        int n;
        awaddr <= '0;
        awvalid <= 1'b0;
        wdata <= '0;
        wstrb <= '0;
        wvalid <= 1'b0;
        bready <= 1'b0;
        araddr <= '0;
        arvalid <= 1'b0;
        rready <= 1'b0;
        iRx <= '0;
        qRx <= '0;
        sampleValid <= 1'b0;
        refPhase = '0;
        refIPrev = 0;
        refQPrev = 0;
        expByte = '0;
        phIdx = 0;
        n = 0;
        @(posedge clk);
        while (rst && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (rst) reportTimeout("reset release");

        // registers read back what was written, and byte lanes merge.
        regWrite(12'h000, 32'h1234_5678, 4'hf);
        regRead(12'h000, 32'h1234_5678);
        regWrite(12'h100, 32'h0000_000c, 4'hf);
        regRead(12'h100, 32'h0000_000c);
        regWrite(12'h104, 32'h0000_0002, 4'hf);
        regRead(12'h104, 32'h0000_0002);
        regRead(12'h108, 32'h0);
        regWrite(12'h000, 32'haabb_ccdd, 4'b0101);
        regRead(12'h000, 32'h12bb_56dd);
        reportTest(1, "register readback");

        // space 3 is unmapped, so the write must not reach the DDC.
        axiWrite(12'h300, 32'hffff_ffff, 4'hf, 3, resp);
        expectEqual("bresp", resp, SLVERR);
        axiRead(12'h304, 3, data, resp);
        expectEqual("rresp", resp, SLVERR);
        expectEqual("rdata", data, 32'h0);
        regRead(12'h000, 32'h12bb_56dd);
        reportTest(2, "unmapped access");

        setupRun(32'h0, 8, 1'b0);
        sendBits(40, 0, 2);
        waitBits(40);
        expectEqual("byte count", bytesSeen, 5);
        reportTest(3, "bit recovery");

        // a quarter turn per sample carrier that the DDC takes out. The run
        // stops half way through a byte, so the next setup must clear the
        // byte phase.
        setupRun(32'h4000_0000, 8, 1'b1);
        sendBits(36, 4, 2);
        waitBits(36);
        reportTest(4, "rotation and inversion");

        setupRun(32'h0, 6, 1'b0);
        sendBits(32, 0, 1);
        waitBits(32);
        expectEqual("byte count", bytesSeen, 4);
        regRead(12'h108, 32'd32);
        reportTest(5, "byte assembly and counter");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tbClock.sv ====
`default_nettype none

// clock and reset source for the testbench.
module tbClock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    // reset is held high for the first four rising edges.
    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

    // a 4 ns period, so the clock toggles every 2 ns.
    always #2 clk = ~clk;

endmodule

`default_nettype wire

// ==== rtl/demod.sv ====
`default_nettype none

module demod
    import demodPkg::*;
#(
    parameter int SPS_WIDTH = SPS_WIDTH_DEFAULT
) (
    input  wire logic     clk,
    input  wire logic     rst,
    // AXI4-Lite host port.
    input  wire regAddr_t awaddr,
    input  wire logic     awvalid,
    output logic          awready,
    input  wire regData_t wdata,
    input  wire regStrb_t wstrb,
    input  wire logic     wvalid,
    output logic          wready,
    output axiResp_t      bresp,
    output logic          bvalid,
    input  wire logic     bready,
    input  wire regAddr_t araddr,
    input  wire logic     arvalid,
    output logic          arready,
    output regData_t      rdata,
    output axiResp_t      rresp,
    output logic          rvalid,
    input  wire logic     rready,
    // complex baseband in, recovered data out.
    input  wire sample_t  iRx,
    input  wire sample_t  qRx,
    input  wire logic     sampleValid,
    output logic          demodBit,
    output logic          demodBitValid,
    output logic [7:0]    demodData,
    output logic          demodDataValid
);

    sample_t iDdc;
    sample_t qDdc;
    logic    ddcValid;
    freq_t   freq;
    logic    freqValid;

    regBus bus ();

    ////////////////////////////////////////////////////////////////////////////
    // host access. every block hangs off the same register bus.
    axiLiteRegBridge axiLiteRegBridge (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .bus(bus.master)
    );

    ////////////////////////////////////////////////////////////////////////////
    // datapath. ddc, then the discriminator, then the bit decision.
    ddc ddc (
        .clk(clk), .rst(rst),
        .bus(bus.slave),
        .iIn(iRx), .qIn(qRx), .inValid(sampleValid),
        .iOut(iDdc), .qOut(qDdc), .outValid(ddcValid)
    );

    fmDemod fmDemod (
        .clk(clk), .rst(rst),
        .iIn(iDdc), .qIn(qDdc), .inValid(ddcValid),
        .freq(freq), .freqValid(freqValid)
    );

    bitsync #(
        .SPS_WIDTH(SPS_WIDTH)
    ) bitsync (
        .clk(clk), .rst(rst),
        .bus(bus.slave),
        .freq(freq), .freqValid(freqValid),
        .demodBit(demodBit), .demodBitValid(demodBitValid),
        .demodData(demodData), .demodDataValid(demodDataValid)
    );

endmodule

`default_nettype wire

// ==== bitsync/bitsync.sv ====
`default_nettype none

module bitsync
    import demodPkg::*;
#(
    parameter int SPS_WIDTH = SPS_WIDTH_DEFAULT
) (
    input  wire logic  clk,
    input  wire logic  rst,
    regBus.slave       bus,
    input  wire freq_t freq,
    input  wire logic  freqValid,
    output logic       demodBit,
    output logic       demodBitValid,
    output logic [7:0] demodData,
    output logic       demodDataValid
);

    // the accumulator must hold a full symbol of worst case samples.
    localparam int ACC_WIDTH = $bits(freq_t) + SPS_WIDTH;

    typedef logic signed [ACC_WIDTH-1:0] acc_t;

    logic [SPS_WIDTH-1:0] sps;
    logic                 enable;
    logic                 invert;
    regData_t             symCount;
    regOffset_t           offset;
    logic                 regWr;
    regData_t             spsMerged;
    regData_t             ctrlMerged;
    regData_t             rdBack;
    logic                 startEnable;
    acc_t                 acc;
    acc_t                 accSum;
    logic [SPS_WIDTH-1:0] sampleCount;
    logic [2:0]           bitPhase;
    logic                 symbolDone;
    logic                 bitNext;

    ////////////////////////////////////////////////////////////////////////////
    // registers. Turning enable on from off also restarts the symbol count.
    assign offset      = offsetOf(bus.addr);
    assign regWr       = bus.wr && (spaceOf(bus.addr) == BITSYNC_SPACE);
    assign spsMerged   = applyStrb(regData_t'(sps), bus.wrData, bus.wrStrb);
    assign ctrlMerged  = applyStrb({30'd0, invert, enable}, bus.wrData, bus.wrStrb);
    assign startEnable = regWr && (offset == BS_CTRL_REG) && ctrlMerged[0] && !enable;

    always_ff @(posedge clk) begin
        if (rst) begin
            sps    <= SPS_WIDTH'(SPS_RESET);
            enable <= 1'b0;
            invert <= 1'b0;
        end else if (regWr) begin
            if (offset == BS_SPS_REG) sps <= spsMerged[SPS_WIDTH-1:0];
            if (offset == BS_CTRL_REG) begin
                enable <= ctrlMerged[0];
                invert <= ctrlMerged[1];
            end
        end
    end

    always_comb begin
        case (offset)
            BS_SPS_REG:   rdBack = regData_t'(sps);
            BS_CTRL_REG:  rdBack = {30'd0, invert, enable};
            BS_COUNT_REG: rdBack = symCount;
            default:      rdBack = '0;
        endcase
    end
    assign bus.rdData[int'(BITSYNC_SPACE)] = rdBack;

    ////////////////////////////////////////////////////////////////////////////
    // integrate and dump. A zero sps gives the longest symbol, 2^SPS_WIDTH.
    assign accSum     = acc + acc_t'(freq);
    assign symbolDone = enable && freqValid && (sampleCount == sps - 1'b1);
    assign bitNext    = !accSum[ACC_WIDTH-1] ^ invert;

    always_ff @(posedge clk) begin
        if (rst || !enable) begin
            acc            <= '0;
            sampleCount    <= '0;
            bitPhase       <= '0;
            demodBitValid  <= 1'b0;
            demodDataValid <= 1'b0;
        end else begin
            demodBitValid  <= symbolDone;
            demodDataValid <= symbolDone && (bitPhase == 3'd7);
            if (symbolDone) begin
                acc         <= '0;
                sampleCount <= '0;
                bitPhase    <= bitPhase + 3'd1;
            end else if (freqValid) begin
                acc         <= accSum;
                sampleCount <= sampleCount + 1'b1;
            end
        end
    end

    // the byte shifts in msb first and is complete on every eighth bit.
    always_ff @(posedge clk) begin
        if (symbolDone) begin
            demodBit  <= bitNext;
            demodData <= {demodData[6:0], bitNext};
        end
    end

    always_ff @(posedge clk) begin
        if (rst || startEnable) symCount <= '0;
        else if (symbolDone) symCount <= symCount + 32'd1;
    end

endmodule

`default_nettype wire

// ==== rtl/fmDemod.sv ====
`default_nettype none

module fmDemod
    import demodPkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire sample_t iIn,
    input  wire sample_t qIn,
    input  wire logic    inValid,
    output freq_t        freq,
    output logic         freqValid
);

    localparam int PROD_WIDTH  = 2 * $bits(sample_t);
    localparam int DIFF_WIDTH  = PROD_WIDTH + 1;
    localparam int FREQ_SHIFT  = 18;

    typedef logic signed [PROD_WIDTH-1:0] product_t;
    typedef logic signed [DIFF_WIDTH-1:0] diff_t;

    localparam diff_t FREQ_MAX = diff_t'((1 <<< ($bits(freq_t) - 1)) - 1);
    localparam diff_t FREQ_MIN = -diff_t'(1 <<< ($bits(freq_t) - 1));

    sample_t  iPrev;
    sample_t  qPrev;
    product_t crossA;
    product_t crossB;
    logic     prodValid;
    diff_t    diff;
    diff_t    scaled;
    freq_t    freqNext;

    ////////////////////////////////////////////////////////////////////////////
    // stage one registers the two cross products against the last sample.
    always_ff @(posedge clk) begin
        if (rst) begin
            iPrev     <= '0;
            qPrev     <= '0;
            prodValid <= 1'b0;
            freqValid <= 1'b0;
        end else begin
            prodValid <= inValid;
            freqValid <= prodValid;
            if (inValid) begin
                iPrev <= iIn;
                qPrev <= qIn;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            crossA <= iPrev * qIn;
            crossB <= qPrev * iIn;
        end
    end

    // stage two takes the difference and scales it down. The arithmetic
    // shift floors, so negative results round toward minus infinity.
    assign diff   = diff_t'(crossA) - diff_t'(crossB);
    assign scaled = diff >>> FREQ_SHIFT;

    // only a full scale step at both extremes can reach the clamp.
    always_comb begin
        if (scaled > FREQ_MAX) begin
            freqNext = freq_t'(FREQ_MAX);
        end else if (scaled < FREQ_MIN) begin
            freqNext = freq_t'(FREQ_MIN);
        end else begin
            freqNext = freq_t'(scaled);
        end
    end

    always_ff @(posedge clk) begin
        if (prodValid) begin
            freq <= freqNext;
        end
    end

endmodule

`default_nettype wire

// ==== ddc/ddc.sv ====
`default_nettype none

module ddc
    import demodPkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    regBus.slave         bus,
    input  wire sample_t iIn,
    input  wire sample_t qIn,
    input  wire logic    inValid,
    output sample_t      iOut,
    output sample_t      qOut,
    output logic         outValid
);

    typedef logic [31:0] phase_t;

    localparam sample_t SAMPLE_MAX = {1'b0, {($bits(sample_t) - 1){1'b1}}};

    regData_t freqWord;
    regData_t freqMerged;
    phase_t   phase;
    logic     regWr;

    // negation that clamps the most negative code at the positive limit.
    function automatic sample_t satNeg(sample_t x);
        return (x == ~SAMPLE_MAX) ? SAMPLE_MAX : -x;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // frequency word register, the only register in this space.
    assign regWr = bus.wr && (spaceOf(bus.addr) == DDC_SPACE)
                   && (offsetOf(bus.addr) == DDC_FREQ_REG);
    assign freqMerged = applyStrb(freqWord, bus.wrData, bus.wrStrb);
    assign bus.rdData[int'(DDC_SPACE)] =
        (offsetOf(bus.addr) == DDC_FREQ_REG) ? freqWord : '0;

    // the phase only moves on a valid sample, so the rotation stays in step
    // with the sample stream and not with the clock.
    always_ff @(posedge clk) begin
        if (rst) begin
            freqWord <= '0;
            phase    <= '0;
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
            if (regWr) begin
                freqWord <= freqMerged;
            end
            if (inValid) begin
                phase <= phase + freqWord;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // coarse downconversion by -0, -90, -180 or -270 degrees, picked by the
    // top two phase bits before this sample's increment.
    always_ff @(posedge clk) begin
        if (inValid) begin
            case (phase[31:30])
                2'd0: begin
                    iOut <= iIn;
                    qOut <= qIn;
                end
                2'd1: begin
                    iOut <= qIn;
                    qOut <= satNeg(iIn);
                end
                2'd2: begin
                    iOut <= satNeg(iIn);
                    qOut <= satNeg(qIn);
                end
                default: begin
                    iOut <= satNeg(qIn);
                    qOut <= iIn;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/axiLiteRegBridge.sv ====
`default_nettype none

module axiLiteRegBridge
    import demodPkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire regAddr_t awaddr,
    input  wire logic     awvalid,
    output logic          awready,
    input  wire regData_t wdata,
    input  wire regStrb_t wstrb,
    input  wire logic     wvalid,
    output logic          wready,
    output axiResp_t      bresp,
    output logic          bvalid,
    input  wire logic     bready,
    input  wire regAddr_t araddr,
    input  wire logic     arvalid,
    output logic          arready,
    output regData_t      rdata,
    output axiResp_t      rresp,
    output logic          rvalid,
    input  wire logic     rready,
    regBus.master         bus
);

    bridgeState_t state;
    space_t       wrSpace;
    space_t       rdSpace;
    logic         wrAccept;
    logic         rdAccept;
    regData_t     rdMux;

    function automatic logic isMapped(space_t s);
        return (s == DDC_SPACE) || (s == BITSYNC_SPACE);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // handshake. A write needs address and data together and wins over a read.
    assign wrSpace  = spaceOf(awaddr);
    assign rdSpace  = spaceOf(araddr);
    assign wrAccept = (state == BRIDGE_IDLE) && awvalid && wvalid;
    assign rdAccept = (state == BRIDGE_IDLE) && arvalid && !(awvalid && wvalid);
    assign awready  = wrAccept;
    assign wready   = wrAccept;
    assign arready  = rdAccept;
    assign bvalid   = (state == BRIDGE_WRESP);
    assign rvalid   = (state == BRIDGE_RRESP);

    // the register bus strobes fire in the accept cycle. Unmapped accesses
    // never reach the blocks.
    assign bus.addr   = wrAccept ? awaddr : araddr;
    assign bus.wrData = wdata;
    assign bus.wrStrb = wstrb;
    assign bus.wr     = wrAccept && isMapped(wrSpace);
    assign bus.rd     = rdAccept && isMapped(rdSpace);

    ////////////////////////////////////////////////////////////////////////////
    // readback mux, one arm per block space. Unmapped spaces read as zero.
    always_comb begin
        case (rdSpace)
            DDC_SPACE:     rdMux = bus.rdData[int'(DDC_SPACE)];
            BITSYNC_SPACE: rdMux = bus.rdData[int'(BITSYNC_SPACE)];
            default:       rdMux = '0;
        endcase
    end

    // response FSM. Each response stays up until the host takes it.
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= BRIDGE_IDLE;
        end else begin
            case (state)
                BRIDGE_IDLE: begin
                    if (wrAccept) begin
                        state <= BRIDGE_WRESP;
                    end else if (rdAccept) begin
                        state <= BRIDGE_RRESP;
                    end
                end
                BRIDGE_WRESP: if (bready) state <= BRIDGE_IDLE;
                BRIDGE_RRESP: if (rready) state <= BRIDGE_IDLE;
                default:      state <= BRIDGE_IDLE;
            endcase
        end
    end

    // response payload is captured once per accepted transaction.
    always_ff @(posedge clk) begin
        if (wrAccept) begin
            bresp <= isMapped(wrSpace) ? RESP_OKAY : RESP_SLVERR;
        end
        if (rdAccept) begin
            rdata <= rdMux;
            rresp <= isMapped(rdSpace) ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

`default_nettype wire

// ==== common/regBus.sv ====
`default_nettype none

// internal register bus between the AXI bridge and the datapath blocks.
// the bridge drives the request side as single cycle strobes, and each
// block returns its readback on its own slot of rdData.
interface regBus
    import demodPkg::*;
();

    regAddr_t addr;
    regData_t wrData;
    regStrb_t wrStrb;
    logic     wr;
    logic     rd;

    // one readback word per block space, indexed by the space number.
    regData_t rdData [NUM_SPACES];

    modport master (
        output addr, wrData, wrStrb, wr, rd,
        input  rdData
    );

    modport slave (
        input  addr, wrData, wrStrb, wr, rd,
        output rdData
    );

endinterface

`default_nettype wire

// ==== common/demodPkg.sv ====
`default_nettype none

package demodPkg;

    // sample and discriminator widths used along the datapath.
    typedef logic signed [17:0] sample_t;
    typedef logic signed [17:0] freq_t;

    // register bus words. The top four address bits pick a block space.
    typedef logic [11:0] regAddr_t;
    typedef logic [31:0] regData_t;
    typedef logic [3:0]  regStrb_t;
    typedef logic [3:0]  space_t;
    typedef logic [7:0]  regOffset_t;
    typedef logic [1:0]  axiResp_t;

    localparam axiResp_t RESP_OKAY   = 2'b00;
    localparam axiResp_t RESP_SLVERR = 2'b10;

    // block spaces. DDC starts at byte 0x000, bitsync at byte 0x100.
    localparam int     NUM_SPACES    = 2;
    localparam space_t DDC_SPACE     = 4'h0;
    localparam space_t BITSYNC_SPACE = 4'h1;

    // register offsets inside each space.
    localparam regOffset_t DDC_FREQ_REG = 8'h00;
    localparam regOffset_t BS_SPS_REG   = 8'h00;
    localparam regOffset_t BS_CTRL_REG  = 8'h04;
    localparam regOffset_t BS_COUNT_REG = 8'h08;

    localparam int SPS_WIDTH_DEFAULT = 8;
    localparam int SPS_RESET         = 8;

    typedef enum logic [1:0] {
        BRIDGE_IDLE,
        BRIDGE_WRESP,
        BRIDGE_RRESP
    } bridgeState_t;

    function automatic space_t spaceOf(regAddr_t a);
        return a[11:8];
    endfunction

    function automatic regOffset_t offsetOf(regAddr_t a);
        return a[7:0];
    endfunction

    // merges a write into an old register value one byte lane at a time.
    function automatic regData_t applyStrb(regData_t old, regData_t data, regStrb_t strb);
        regData_t merged;
        merged = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

`default_nettype wire
